/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
TOP        := character_tb
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/button_edge.sv */
module button_edge (
    input  logic character_clk,
    input  logic sys_rst_n,
    input  logic left_btn,
    input  logic right_btn,
    input  logic jump_btn,
    output logic left_edge,
    output logic right_edge,
    output logic jump_edge
);

    logic [2:0] btn_now;
    logic [2:0] btn_d;                      // last sampled level

    assign btn_now = {jump_btn, right_btn, left_btn};

    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            btn_d                              <= 3'b000;
            {jump_edge, right_edge, left_edge} <= 3'b000;
        end else begin
            btn_d                              <= btn_now;
            {jump_edge, right_edge, left_edge} <= btn_now & ~btn_d;   // high for one clock
        end
    end

endmodule

/* logic/character_apb_regs.sv */
module character_apb_regs (
    input  logic                                     character_clk,
    input  logic                                     sys_rst_n,
    input  logic                                     psel,
    input  logic                                     penable,
    input  logic                                     pwrite,
    input  logic [7:0]                               paddr,
    input  logic [31:0]                              pwdata,
    input  character_pkg::char_state_e               state,
    input  logic signed [1:0]                        face,
    input  logic [6:0]                               jump_cnt,
    input  logic signed [character_pkg::PHY_WIDTH:0] pos_x,
    input  logic signed [character_pkg::PHY_WIDTH:0] pos_y,
    input  logic signed [character_pkg::PHY_WIDTH:0] vel_x,
    input  logic signed [character_pkg::PHY_WIDTH:0] vel_y,
    output logic [31:0]                              prdata,
    output logic                                     pslverr,
    output logic                                     respawn
);

    character_pkg::char_word_u pos_word;
    character_pkg::char_word_u vel_word;
    logic [31:0]               status_word;
    logic                      access;         // APB access phase
    logic                      addr_ok;

    function automatic logic [15:0] sext16(input logic signed [character_pkg::PHY_WIDTH:0] v);
        return {{(15 - character_pkg::PHY_WIDTH){v[character_pkg::PHY_WIDTH]}}, v};
    endfunction

    always_comb begin
        pos_word.pair.x = sext16(pos_x);
        pos_word.pair.y = sext16(pos_y);
        vel_word.pair.x = sext16(vel_x);
        vel_word.pair.y = sext16(vel_y);
    end

    assign status_word = {17'd0, jump_cnt, 2'b00, face, 1'b0, state};

    assign access  = psel && penable;
    assign addr_ok = paddr inside {character_pkg::REG_POS, character_pkg::REG_VEL,
                                   character_pkg::REG_STATUS, character_pkg::REG_CTRL};
    // only REG_CTRL takes writes
    assign pslverr = access && (!addr_ok || (pwrite && paddr != character_pkg::REG_CTRL));

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                character_pkg::REG_POS:    prdata = pos_word.raw;
                character_pkg::REG_VEL:    prdata = vel_word.raw;
                character_pkg::REG_STATUS: prdata = status_word;
                default:                   prdata = '0;   // ctrl reads back zero
            endcase
        end
    end

    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            respawn <= 1'b0;
        end else begin
            respawn <= access && pwrite && (paddr == character_pkg::REG_CTRL) && pwdata[0];
        end
    end

endmodule

/* logic/character_motion.sv */
module character_motion (
    input  logic                                     character_clk,
    input  logic                                     sys_rst_n,
    input  logic                                     left_edge,
    input  logic                                     right_edge,
    input  logic                                     jump_edge,
    input  logic                                     jump_btn,
    input  logic                                     respawn,
    input  logic [1:0]                               collision_type,
    input  logic                                     on_ground,
    input  logic signed [character_pkg::PHY_WIDTH:0] land_dist,
    output character_pkg::char_state_e               state,
    output logic signed [1:0]                        face,
    output logic [6:0]                               jump_cnt,
    output logic signed [character_pkg::PHY_WIDTH:0] pos_x,
    output logic signed [character_pkg::PHY_WIDTH:0] pos_y,
    output logic signed [character_pkg::PHY_WIDTH:0] vel_x,
    output logic signed [character_pkg::PHY_WIDTH:0] vel_y
);

    character_pkg::char_state_e next_state;

    logic landing;                          // falling and sunk into the floor
    logic bump_x;                           // moving into a side wall
    logic bump_y;                           // rising into the ceiling
    logic airborne;
    logic max_charge;
    logic near_high;
    logic vx_pos;
    logic vx_neg;
    logic vy_pos;
    logic signed [character_pkg::PHY_WIDTH:0] jump_factor;
    logic signed [character_pkg::PHY_WIDTH:0] face_ext;
    logic signed [character_pkg::PHY_WIDTH:0] step_x;
    logic signed [character_pkg::PHY_WIDTH:0] vx_c;
    logic signed [character_pkg::PHY_WIDTH:0] vy_c;
    logic signed [character_pkg::PHY_WIDTH:0] vx_nxt;
    logic signed [character_pkg::PHY_WIDTH:0] vy_nxt;
    logic signed [character_pkg::PHY_WIDTH:0] px_nxt;
    logic signed [character_pkg::PHY_WIDTH:0] py_nxt;

    function automatic logic signed [character_pkg::PHY_WIDTH:0] clamp_vel(
        input logic signed [character_pkg::PHY_WIDTH:0] v
    );
        if (v > character_pkg::MAX_VEL) begin
            return character_pkg::MAX_VEL;
        end else if (v < -character_pkg::MAX_VEL) begin
            return -character_pkg::MAX_VEL;
        end
        return v;
    endfunction

    // ----------------------------------------------------------
    // collision reaction
    // ----------------------------------------------------------
    assign vx_neg    = vel_x[character_pkg::PHY_WIDTH];
    assign vx_pos    = !vel_x[character_pkg::PHY_WIDTH] && (vel_x != '0);
    assign vy_pos    = !vel_y[character_pkg::PHY_WIDTH] && (vel_y != '0);
    assign near_high = int'(pos_x) > character_pkg::INITIAL_POS_X;   // left wall sits at high x

    // only react while still heading in, the sensed position lags by a clock
    assign landing  = (collision_type == 2'd1) && (land_dist != '0)
                      && vel_y[character_pkg::PHY_WIDTH];
    assign bump_y   = (collision_type == 2'd1) && vy_pos;
    assign bump_x   = (collision_type == 2'd2) && (near_high ? vx_pos : vx_neg);
    assign airborne = !on_ground && (state != character_pkg::LAND);

    assign max_charge = (state == character_pkg::CHARGE)
                        && (jump_cnt >= character_pkg::MAX_CHARGE);
    assign face_ext   = {{(character_pkg::PHY_WIDTH - 1){face[1]}}, face};

    // ----------------------------------------------------------
    // FSM
    // ----------------------------------------------------------
    always_comb begin
        if (landing) begin
            next_state = character_pkg::LAND;
        end else if (bump_x || bump_y) begin
            next_state = character_pkg::COLLISION;
        end else begin
            case (state)
                character_pkg::IDLE, character_pkg::LEFT, character_pkg::RIGHT: begin
                    if (left_edge) begin
                        next_state = character_pkg::LEFT;
                    end else if (right_edge) begin
                        next_state = character_pkg::RIGHT;
                    end else if (jump_edge) begin
                        next_state = character_pkg::CHARGE;
                    end else begin
                        next_state = character_pkg::IDLE;
                    end
                end
                character_pkg::CHARGE: begin
                    next_state = (max_charge || !jump_btn) ? character_pkg::JUMP
                                                           : character_pkg::CHARGE;
                end
                default: next_state = character_pkg::IDLE;
            endcase
        end
    end

    always_comb begin
        if (jump_cnt <= character_pkg::MAX_CHARGE / 4) begin
            jump_factor = 11'sd1;
        end else if (jump_cnt <= character_pkg::MAX_CHARGE / 2) begin
            jump_factor = 11'sd2;
        end else if (jump_cnt <= character_pkg::MAX_CHARGE - character_pkg::MAX_CHARGE / 4) begin
            jump_factor = 11'sd3;
        end else begin
            jump_factor = 11'sd4;
        end
    end

    // walking step lands together with the state change
    assign step_x = (next_state == character_pkg::LEFT)  ?  character_pkg::STEP_X :
                    (next_state == character_pkg::RIGHT) ? -character_pkg::STEP_X : '0;

    // ----------------------------------------------------------
    // integration
    // ----------------------------------------------------------
    always_comb begin
        vx_c = vel_x;
        vy_c = vel_y;
        if (state == character_pkg::JUMP) begin
            vx_c = character_pkg::JUMP_VEL_X * jump_factor * face_ext;
            vy_c = character_pkg::JUMP_VEL_Y * jump_factor;
        end
        if (bump_x) begin
            vx_c = -vel_x;
        end
        if (bump_y) begin
            vy_c = -vel_y;
        end
        if (airborne) begin
            vy_c = vy_c + character_pkg::GRAVITY;
        end
        vx_nxt = clamp_vel(vx_c);
        vy_nxt = clamp_vel(vy_c);
        px_nxt = pos_x + step_x + vx_nxt;
        py_nxt = pos_y + vy_nxt;
        if (landing) begin
            vx_nxt = '0;
            vy_nxt = '0;
            px_nxt = pos_x;
            py_nxt = pos_y - vel_y + land_dist;   // back to the sensed spot, then up to the floor
        end
    end

    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state    <= character_pkg::IDLE;
            face     <= 2'sd1;
            jump_cnt <= 7'd1;
            pos_x    <= (character_pkg::PHY_WIDTH + 1)'(character_pkg::INITIAL_POS_X);
            pos_y    <= (character_pkg::PHY_WIDTH + 1)'(character_pkg::INITIAL_POS_Y);
            vel_x    <= '0;
            vel_y    <= '0;
        end else if (respawn) begin
            state    <= character_pkg::IDLE;
            face     <= 2'sd1;
            jump_cnt <= 7'd1;
            pos_x    <= (character_pkg::PHY_WIDTH + 1)'(character_pkg::INITIAL_POS_X);
            pos_y    <= (character_pkg::PHY_WIDTH + 1)'(character_pkg::INITIAL_POS_Y);
            vel_x    <= '0;
            vel_y    <= '0;
        end else begin
            state <= next_state;
            if (state == character_pkg::CHARGE) begin
                jump_cnt <= jump_cnt + character_pkg::JUMP_INCREMENT;
            end else if (state == character_pkg::JUMP) begin
                jump_cnt <= 7'd1;
            end
            if (bump_x) begin
                face <= -face;
            end else if (next_state == character_pkg::LEFT) begin
                face <= 2'sd1;
            end else if (next_state == character_pkg::RIGHT) begin
                face <= -2'sd1;
            end
            pos_x <= px_nxt;
            pos_y <= py_nxt;
            vel_x <= vx_nxt;
            vel_y <= vy_nxt;
        end
    end

endmodule

/* logic/character_pkg.sv */
package character_pkg;

    // ----------------------------------------------------------
    // geometry, all in pixels
    // ----------------------------------------------------------
    localparam int PHY_WIDTH = 10;          // msb index, physics words are 11 bits signed

    localparam int WALL_WIDTH   = 10;
    localparam int MAP_WIDTH_X  = 100;
    localparam int MAP_WIDTH_Y  = 100;
    localparam int MAP_X_OFFSET = 270;
    localparam int MAP_Y_OFFSET = 50;

    localparam int CHAR_WIDTH_X = 32;
    localparam int CHAR_WIDTH_Y = 32;

    // centred in x, standing on the floor
    localparam int INITIAL_POS_X = MAP_X_OFFSET + (MAP_WIDTH_X - CHAR_WIDTH_X) / 2;
    localparam int INITIAL_POS_Y = MAP_Y_OFFSET + WALL_WIDTH;

    // ----------------------------------------------------------
    // physics
    // ----------------------------------------------------------
    localparam logic signed [PHY_WIDTH:0] MAX_VEL    = 11'sd40;
    localparam logic signed [PHY_WIDTH:0] GRAVITY    = -11'sd1;
    localparam logic signed [PHY_WIDTH:0] STEP_X     = 11'sd1;   // +x is left
    localparam logic signed [PHY_WIDTH:0] JUMP_VEL_X = 11'sd4;
    localparam logic signed [PHY_WIDTH:0] JUMP_VEL_Y = 11'sd8;

    localparam logic [6:0] MAX_CHARGE     = 7'd100;
    localparam logic [6:0] JUMP_INCREMENT = 7'd10;

    typedef enum logic [2:0] {
        IDLE,
        LEFT,
        RIGHT,
        CHARGE,
        JUMP,
        COLLISION,
        LAND
    } char_state_e;

    // ----------------------------------------------------------
    // register map
    // ----------------------------------------------------------
    localparam logic [7:0] REG_POS    = 8'h00;
    localparam logic [7:0] REG_VEL    = 8'h04;
    localparam logic [7:0] REG_STATUS = 8'h08;
    localparam logic [7:0] REG_CTRL   = 8'h0C;

    // bus word, or an x/y pair of sign-extended halves
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [15:0] x;                 // upper half
            logic [15:0] y;
        } pair;
    } char_word_u;

endpackage

/* logic/character_top.sv */
module character_top (
    input  logic        character_clk,
    input  logic        sys_rst_n,
    input  logic        left_btn,
    input  logic        right_btn,
    input  logic        jump_btn,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pslverr
);

    logic left_edge;
    logic right_edge;
    logic jump_edge;
    logic respawn;
    logic on_ground;
    logic [1:0] collision_type;
    logic signed [character_pkg::PHY_WIDTH:0] land_dist;

    character_pkg::char_state_e               state;
    logic signed [1:0]                        face;
    logic [6:0]                               jump_cnt;
    logic signed [character_pkg::PHY_WIDTH:0] pos_x;
    logic signed [character_pkg::PHY_WIDTH:0] pos_y;
    logic signed [character_pkg::PHY_WIDTH:0] vel_x;
    logic signed [character_pkg::PHY_WIDTH:0] vel_y;

    button_edge button_edge_i (
        .character_clk, .sys_rst_n,
        .left_btn, .right_btn, .jump_btn,
        .left_edge, .right_edge, .jump_edge
    );

    wall_sense wall_sense_i (
        .character_clk, .sys_rst_n,
        .pos_x, .pos_y,
        .collision_type, .on_ground, .land_dist
    );

    character_motion character_motion_i (
        .character_clk, .sys_rst_n,
        .left_edge, .right_edge, .jump_edge, .jump_btn,
        .respawn,
        .collision_type, .on_ground, .land_dist,
        .state, .face, .jump_cnt,
        .pos_x, .pos_y, .vel_x, .vel_y
    );

    character_apb_regs character_apb_regs_i (
        .character_clk, .sys_rst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .state, .face, .jump_cnt,
        .pos_x, .pos_y, .vel_x, .vel_y,
        .prdata, .pslverr, .respawn
    );

endmodule

/* logic/wall_sense.sv */
module wall_sense (
    input  logic                                     character_clk,
    input  logic                                     sys_rst_n,
    input  logic signed [character_pkg::PHY_WIDTH:0] pos_x,
    input  logic signed [character_pkg::PHY_WIDTH:0] pos_y,
    output logic [1:0]                               collision_type,
    output logic                                     on_ground,
    output logic signed [character_pkg::PHY_WIDTH:0] land_dist
);

    logic [character_pkg::CHAR_WIDTH_X-1:0] col_in;    // column inside the map interior
    logic [character_pkg::MAX_VEL+1:0]      row_in;    // box rows plus the deepest sink
    logic                                   below_in;
    logic [1:0]                             coll_c;
    logic signed [character_pkg::PHY_WIDTH:0] dist_c;

    function automatic logic in_x(input int x);
        return x >= character_pkg::MAP_X_OFFSET + character_pkg::WALL_WIDTH &&
               x <  character_pkg::MAP_X_OFFSET + character_pkg::MAP_WIDTH_X
                    - character_pkg::WALL_WIDTH;
    endfunction

    function automatic logic in_y(input int y);
        return y >= character_pkg::MAP_Y_OFFSET + character_pkg::WALL_WIDTH &&
               y <  character_pkg::MAP_Y_OFFSET + character_pkg::MAP_WIDTH_Y
                    - character_pkg::WALL_WIDTH;
    endfunction

    always_comb begin
        int px;
        int py;
        px = int'(pos_x);
        py = int'(pos_y);
        for (int i = 0; i < character_pkg::CHAR_WIDTH_X; i++) begin
            col_in[i] = in_x(px + i);
        end
        for (int i = 0; i <= int'(character_pkg::MAX_VEL) + 1; i++) begin
            row_in[i] = in_y(py + i);
        end
        below_in = in_y(py - 1);

        // floor or ceiling wins over a side wall
        if (!(&row_in[character_pkg::CHAR_WIDTH_Y-1:0])) begin
            coll_c = 2'd1;
        end else if (!(&col_in)) begin
            coll_c = 2'd2;
        end else begin
            coll_c = 2'd0;
        end

        // sunk into the floor, find the lowest free row
        dist_c = '0;
        if (!row_in[0]) begin
            for (int i = int'(character_pkg::MAX_VEL) + 1; i >= 1; i--) begin
                if (row_in[i]) begin
                    dist_c = (character_pkg::PHY_WIDTH + 1)'(i);
                end
            end
        end
    end

    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            collision_type <= 2'd0;
            on_ground      <= 1'b1;         // rest position stands on the floor
            land_dist      <= '0;
        end else begin
            collision_type <= coll_c;
            on_ground      <= row_in[0] && !below_in;
            land_dist      <= dist_c;
        end
    end

endmodule

/* tb.f */
logic/character_pkg.sv
logic/button_edge.sv
logic/wall_sense.sv
logic/character_motion.sv
logic/character_apb_regs.sv
logic/character_top.sv
verification/character_assert.sv
verification/character_tb.sv

/* verification/character_assert.sv */
module character_assert (
    input logic                                     character_clk,
    input logic                                     sys_rst_n,
    input logic                                     psel,
    input logic                                     penable,
    input logic                                     respawn,
    input logic                                     left_edge,
    input logic                                     right_edge,
    input logic                                     on_ground,
    input character_pkg::char_state_e               state,
    input logic signed [character_pkg::PHY_WIDTH:0] pos_x,
    input logic signed [character_pkg::PHY_WIDTH:0] vel_x
);

    logic at_rest;                          // standing still on the floor

    assign at_rest = on_ground && (state == character_pkg::IDLE) && (vel_x == '0) && !respawn;

    // access phase always follows a setup phase
    apb_setup_first: assert property (@(posedge character_clk) disable iff (!sys_rst_n)
        $rose(penable) |-> $past(psel))
        else $error("penable rose without psel in the previous cycle");

    respawn_single: assert property (@(posedge character_clk) disable iff (!sys_rst_n)
        respawn |=> !respawn)
        else $error("respawn held for more than one clock");

    // walking step shows up the clock after the edge pulse
    step_left: assert property (@(posedge character_clk) disable iff (!sys_rst_n)
        (left_edge && at_rest) |=> (pos_x == $past(pos_x) + 11'sd1))
        else $error("left press did not move pos_x by one pixel");

    step_right: assert property (@(posedge character_clk) disable iff (!sys_rst_n)
        (right_edge && !left_edge && at_rest) |=> (pos_x == $past(pos_x) - 11'sd1))
        else $error("right press did not move pos_x by one pixel");

endmodule

bind character_top character_assert assert_i (
    .character_clk (character_clk),
    .sys_rst_n     (sys_rst_n),
    .psel          (psel),
    .penable       (penable),
    .respawn       (respawn),
    .left_edge     (left_edge),
    .right_edge    (right_edge),
    .on_ground     (on_ground),
    .state         (state),
    .pos_x         (pos_x),
    .vel_x         (vel_x)
);

/* verification/character_tb.sv */
module character_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int NUM_ROWS     = 19;
    localparam int MAX_POLLS    = 200;
    localparam int MAX_ROW_CLKS = 1500;     // settle row, 200 polls of three clocks plus reads
    localparam int SEED         = 30868;

    typedef enum {OP_READ, OP_WRITE, OP_WALK, OP_CHARGE, OP_SETTLE} op_e;

    typedef struct {
        op_e         act;
        logic [7:0]  addr;
        logic [31:0] data;                  // write data or expected read word
        logic [31:0] mask;
        logic        err;
        int          arg;
    } row_t;

    logic        character_clk;
    logic        sys_rst_n;
    logic        left_btn;
    logic        right_btn;
    logic        jump_btn;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pslverr;

    row_t rows [NUM_ROWS];
    int   err_cnt;
    int   check_cnt;
    int   row_err;
    int   model_x;                          // expected pos_x while walking
    int   model_face;

    character_top dut_i (
        .character_clk, .sys_rst_n,
        .left_btn, .right_btn, .jump_btn,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pslverr
    );

    initial begin
        character_clk = 1'b0;
        forever #(CLK_PERIOD / 2) character_clk = ~character_clk;
    end

    initial begin
        #(NUM_ROWS * MAX_ROW_CLKS * CLK_PERIOD);
        $display("watchdog expired before the table was done");
        $display("TB FAILED");
        $finish;
    end

    // ----------------------------------------------------------
    // expected words, built from the register map rules
    // ----------------------------------------------------------
    function automatic logic [31:0] pair_word(input int x, input int y);
        character_pkg::char_word_u w;
        w.pair.x = 16'(x);
        w.pair.y = 16'(y);
        return w.raw;
    endfunction

    function automatic logic [31:0] status_word(input int st, input int fc, input int cnt);
        return (32'(cnt) << 8) | ((32'(fc) & 32'h3) << 4) | (32'(st) & 32'h7);
    endfunction

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp, input logic [31:0] mask);
        check_cnt++;
        if ((got & mask) !== (exp & mask)) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got & mask, exp & mask);
            row_err++;
        end
    endtask

    task automatic step(input int n);
        repeat (n) begin
            @(posedge character_clk);
            #2;
        end
    endtask

    // ----------------------------------------------------------
    // APB, setup then access, sampled mid access
    // ----------------------------------------------------------
    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        step(1);
        penable = 1'b1;
        @(negedge character_clk);
        data = prdata;
        err  = pslverr;
        step(1);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        step(1);
        penable = 1'b1;
        @(negedge character_clk);
        err = pslverr;
        step(1);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic walk(input int presses);
        logic [31:0] rd;
        logic        err;
        bit          go_left;
        for (int i = 0; i < presses; i++) begin
            go_left = ($urandom_range(1, 0) == 1);
            if (go_left) begin
                left_btn = 1'b1;
            end else begin
                right_btn = 1'b1;
            end
            step($urandom_range(4, 1));     // held, still one press
            left_btn  = 1'b0;
            right_btn = 1'b0;
            step(2);
            model_x    = go_left ? model_x + 1 : model_x - 1;   // +x is left
            model_face = go_left ? 1 : 3;
            apb_read(character_pkg::REG_POS, rd, err);
            compare("pos", rd, pair_word(model_x, character_pkg::INITIAL_POS_Y), '1);
            apb_read(character_pkg::REG_STATUS, rd, err);
            compare("face", rd, status_word(0, model_face, 0), 32'h30);
        end
    endtask

    task automatic charge_jump();
        int                        hold;
        logic [31:0]               rd;
        logic                      err;
        character_pkg::char_word_u w;
        hold     = $urandom_range(9, 1);
        jump_btn = 1'b1;
        step(hold);
        // one clock in CHARGE less than the hold at the sample point
        apb_read(character_pkg::REG_STATUS, rd, err);
        compare("status", rd,
                status_word(int'(character_pkg::CHARGE), 0, 1 + 10 * (hold - 1)), 32'h7F07);
        jump_btn = 1'b0;
        step(1);
        apb_read(character_pkg::REG_POS, rd, err);
        w.raw = rd;
        check_cnt++;
        if ($signed(w.pair.y) <= character_pkg::INITIAL_POS_Y) begin
            $display("CHECK FAILED pos_y: got %h expected above %h",
                     w.pair.y, 16'(character_pkg::INITIAL_POS_Y));
            row_err++;
        end
    endtask

    task automatic settle();
        logic [31:0] pos;
        logic [31:0] vel;
        logic [31:0] st;
        logic        err;
        bit          rested;
        rested = 1'b0;
        // velocity is zero again only after the landing
        for (int i = 0; i < MAX_POLLS && !rested; i++) begin
            step(1);
            apb_read(character_pkg::REG_VEL, vel, err);
            rested = (vel == '0);
        end
        check_cnt++;
        if (!rested) begin
            $display("velocity never returned to zero after the jump");
            row_err++;
        end
        apb_read(character_pkg::REG_POS, pos, err);
        apb_read(character_pkg::REG_STATUS, st, err);
        compare("pos_y", pos, pair_word(0, character_pkg::INITIAL_POS_Y), 32'hFFFF);
        compare("state", st, status_word(int'(character_pkg::IDLE), 0, 0), 32'h7);
    endtask

    task automatic set_row(input int i, input op_e act, input logic [7:0] addr,
                           input logic [31:0] data, input logic [31:0] mask,
                           input logic err, input int arg);
        rows[i].act  = act;
        rows[i].addr = addr;
        rows[i].data = data;
        rows[i].mask = mask;
        rows[i].err  = err;
        rows[i].arg  = arg;
    endtask

    task automatic build_table();
        logic [31:0] pos0;
        logic [31:0] st0;
        pos0 = pair_word(character_pkg::INITIAL_POS_X, character_pkg::INITIAL_POS_Y);
        st0  = status_word(int'(character_pkg::IDLE), 1, 1);
        set_row(0,  OP_READ,   character_pkg::REG_POS,    pos0,   '1, 1'b0, 0);
        set_row(1,  OP_READ,   character_pkg::REG_VEL,    '0,     '1, 1'b0, 0);
        set_row(2,  OP_READ,   character_pkg::REG_STATUS, st0,    '1, 1'b0, 0);
        set_row(3,  OP_WALK,   8'h00,                     '0,     '0, 1'b0, 8);
        set_row(4,  OP_WRITE,  character_pkg::REG_CTRL,   32'h1,  '0, 1'b0, 0);
        set_row(5,  OP_READ,   character_pkg::REG_POS,    pos0,   '1, 1'b0, 0);
        set_row(6,  OP_READ,   character_pkg::REG_VEL,    '0,     '1, 1'b0, 0);
        set_row(7,  OP_READ,   character_pkg::REG_STATUS, st0,    '1, 1'b0, 0);
        set_row(8,  OP_CHARGE, 8'h00,                     '0,     '0, 1'b0, 0);
        set_row(9,  OP_SETTLE, 8'h00,                     '0,     '0, 1'b0, 0);
        set_row(10, OP_WRITE,  character_pkg::REG_CTRL,   32'h1,  '0, 1'b0, 0);
        set_row(11, OP_READ,   character_pkg::REG_POS,    pos0,   '1, 1'b0, 0);
        set_row(12, OP_READ,   character_pkg::REG_STATUS, st0,    '1, 1'b0, 0);
        set_row(13, OP_READ,   8'h10,                     '0,     '0, 1'b1, 0);   // unmapped
        set_row(14, OP_READ,   8'h02,                     '0,     '0, 1'b1, 0);
        set_row(15, OP_WRITE,  character_pkg::REG_POS,    '0,     '0, 1'b1, 0);
        set_row(16, OP_WRITE,  character_pkg::REG_VEL,    32'h1234, '0, 1'b1, 0);
        set_row(17, OP_READ,   character_pkg::REG_POS,    pos0,   '1, 1'b0, 0);
        set_row(18, OP_READ,   character_pkg::REG_STATUS, st0,    '1, 1'b0, 0);
    endtask

    task automatic run_row(input int i);
        logic [31:0] rd;
        logic        err;
        row_err = 0;
        case (rows[i].act)
            OP_READ: begin
                apb_read(rows[i].addr, rd, err);
                if (rows[i].mask != '0) begin
                    compare("prdata", rd, rows[i].data, rows[i].mask);
                end
                compare("pslverr", 32'(err), 32'(rows[i].err), 32'h1);
            end
            OP_WRITE: begin
                apb_write(rows[i].addr, rows[i].data, err);
                compare("pslverr", 32'(err), 32'(rows[i].err), 32'h1);
                if (rows[i].addr == character_pkg::REG_CTRL && rows[i].data[0]) begin
                    model_x    = character_pkg::INITIAL_POS_X;
                    model_face = 1;
                end
            end
            OP_WALK:   walk(rows[i].arg);
            OP_CHARGE: charge_jump();
            default:   settle();
        endcase
        err_cnt += row_err;
        $display("row %0d %s %s", i, rows[i].act.name(), (row_err == 0) ? "ok" : "failed");
    endtask

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        sys_rst_n  = 1'b0;
        left_btn   = 1'b0;
        right_btn  = 1'b0;
        jump_btn   = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        err_cnt    = 0;
        check_cnt  = 0;
        model_x    = character_pkg::INITIAL_POS_X;
        model_face = 1;
        build_table();
        repeat (16) @(posedge character_clk);
        #2;
        sys_rst_n = 1'b1;
        step(1);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
            step($urandom_range(3, 0));     // idle gap
        end
        $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
